//--- include/cpc_loader_params.svh
////////////////////////////////////////////////////////////
// Constants for the CPC ROM download loader
// Page bases are 9-bit values for address bits 22..14 of
// the 8 MB ROM/RAM bank, bit 8 selects the high-ROM half
// Include in any file that uses these constants
////////////////////////////////////////////////////////////

`ifndef CPC_LOADER_PARAMS_SVH
`define CPC_LOADER_PARAMS_SVH

// Offset width inside one 16 KB block
`define CPC_BLOCK_BITS 14

// Main ROM page bases
`define CPC_OS_PAGE 9'h000
`define CPC_BASIC_PAGE 9'h100
`define CPC_AMSDOS_PAGE 9'h107
`define CPC_MF2_PAGE 9'h0FF

// Unused page for a malformed expansion extension
`define CPC_BAD_EXT_PAGE 9'h1EE

`define CPC_MAIN_BLOCKS 8
`define CPC_REF_DIV_BITS 3

`endif

//--- logic/cpc_loader_pkg.sv
////////////////////////////////////////////////////////////
// Types shared by the ROM loader blocks and the testbench
// Download records, the start record, the memory address
// union and the write request
////////////////////////////////////////////////////////////

`include "cpc_loader_params.svh"

package cpc_loader_pkg;

	// One byte as it arrives from the host
	typedef struct packed {
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        valid;
	} dl_byte_t;

	// Latched at the start of each download
	typedef struct packed {
		logic [7:0] index;
		logic [8:0] page;
		logic       is_exp;
	} dl_start_t;

	// Split view of a memory address
	typedef struct packed {
		logic                       hi_half;
		logic [7:0]                 page;
		logic [`CPC_BLOCK_BITS-1:0] offset;
	} boot_fields_t;

	typedef union packed {
		logic [22:0]  flat;
		boot_fields_t fields;
	} boot_addr_u;

	// Write request towards the sequencer
	typedef struct packed {
		logic [1:0] bank;
		boot_addr_u addr;
		logic [7:0] data;
		// Copy the byte into bank 1 as well
		logic       replay;
	} mem_write_t;

endpackage

//--- logic/rom_ext_decoder.sv
////////////////////////////////////////////////////////////
// Download start capture for the ROM loader
// On the rising edge of dl_active the file index is latched
// and the expansion page is decoded from the two-character
// file extension. The record holds for the whole download
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cpc_loader_params.svh"

module rom_ext_decoder (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active,
	input  logic [7:0]                dl_index,
	input  logic [15:0]               dl_ext,
	output cpc_loader_pkg::dl_start_t start
);
	import cpc_loader_pkg::*;

	localparam logic [8:0] BAD_PAGE = `CPC_BAD_EXT_PAGE;

	dl_start_t next_start;
	logic      active_q;

	// One hex digit from an ASCII character, else the fallback nibble
	function automatic logic [3:0] hex_digit(input logic [7:0] ch, input logic [3:0] fallback);
		logic [3:0] val;
		val = fallback;
		if (ch >= "0" && ch <= "9") begin
			val = ch[3:0];
		end else if (ch >= "A" && ch <= "F") begin
			val = ch[3:0] + 4'd9;
		end
		return val;
	endfunction

	always_comb begin
		next_start.index  = dl_index;
		next_start.is_exp = |dl_index;
		next_start.page   = {BAD_PAGE[8],
		                     hex_digit(dl_ext[15:8], BAD_PAGE[7:4]),
		                     hex_digit(dl_ext[7:0], BAD_PAGE[3:0])};
		// "ZZ" loads into the low half at page 0
		if (dl_ext == "ZZ") begin
			next_start.page = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q <= 1'b0;
			start    <= '0;
		end else begin
			active_q <= dl_active;
			if (dl_active && !active_q) begin
				start <= next_start;
			end
		end
	end

endmodule

//--- logic/rom_addr_mapper.sv
////////////////////////////////////////////////////////////
// Address mapping for each accepted download byte
// Main ROM blocks go to the OS, BASIC, AMSDOS or MF2 page
// of bank 0 or 1, expansion ROMs go to their decoded page.
// Holds dl_wait high until the write is done or dropped
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cpc_loader_params.svh"

module rom_addr_mapper (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  cpc_loader_pkg::dl_start_t  start,
	input  logic                       dl_wr,
	input  logic [24:0]                dl_addr,
	input  logic [7:0]                 dl_data,
	input  logic                       dl_active,
	input  logic                       done,
	output logic                       dl_wait,
	output logic                       req,
	output cpc_loader_pkg::mem_write_t wr
);
	import cpc_loader_pkg::*;

	dl_byte_t    cur;
	mem_write_t  next_wr;
	logic [10:0] block;
	logic [8:0]  main_page;
	logic        rom_dl;
	logic        drop;
	logic        drop_q;

	// Indexes with a low field of 4 or more belong to other loaders
	assign rom_dl = dl_active && (start.index[4:0] < 5'd4);

	always_comb begin
		cur.index = start.index;
		cur.addr  = dl_addr;
		cur.data  = dl_data;
		cur.valid = dl_wr && rom_dl && !dl_wait;
	end

	assign block = cur.addr[24:`CPC_BLOCK_BITS];

	always_comb begin
		case (block[1:0])
			2'd0: main_page = `CPC_OS_PAGE;
			2'd1: main_page = `CPC_BASIC_PAGE;
			2'd2: main_page = `CPC_AMSDOS_PAGE;
			default: main_page = `CPC_MF2_PAGE;
		endcase
	end

	always_comb begin
		next_wr.data = cur.data;
		drop         = 1'b0;
		if (start.is_exp) begin
			next_wr.addr.fields.hi_half = start.page[8];
			next_wr.addr.fields.page    = start.page[7:0] + cur.addr[21:14];
			next_wr.addr.fields.offset  = cur.addr[`CPC_BLOCK_BITS-1:0];
			next_wr.bank   = {1'b0, &cur.index[7:6]};
			// Manual loads and boot.eXX images land in both banks
			next_wr.replay = (next_wr.bank == 2'd0) &&
			                 (cur.index[7:6] == 2'b01 || |cur.index[5:0]);
		end else begin
			// 6128 set in blocks 0-3, 664 set in blocks 4-7
			next_wr.addr.flat = {main_page, cur.addr[`CPC_BLOCK_BITS-1:0]};
			next_wr.bank      = {1'b0, block[2]};
			next_wr.replay    = 1'b0;
			drop              = block >= `CPC_MAIN_BLOCKS;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait <= 1'b0;
			drop_q  <= 1'b0;
		end else if (cur.valid) begin
			dl_wait <= 1'b1;
			drop_q  <= drop;
		end else if (dl_wait && (drop_q || done)) begin
			dl_wait <= 1'b0;
			drop_q  <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cur.valid) begin
			wr <= next_wr;
		end
	end

	assign req = dl_wait && !drop_q;

endmodule

//--- logic/rom_write_sequencer.sv
////////////////////////////////////////////////////////////
// Memory write side of the ROM loader
// Generates the reference enable, holds each write for one
// enable period, repeats replay bytes into bank 1 and marks
// loaded high-ROM pages in the page map
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "cpc_loader_params.svh"

module rom_write_sequencer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       req,
	input  cpc_loader_pkg::mem_write_t wr,
	output logic                       done,
	output logic                       mem_ref,
	output logic                       mem_we,
	output logic [1:0]                 mem_bank,
	output logic [22:0]                mem_addr,
	output logic [7:0]                 mem_data,
	output logic [255:0]               rom_map
);

	logic [`CPC_REF_DIV_BITS-1:0] div;
	// Set while the bank-1 copy of a replay byte is pending
	logic                         second;

	////////////////////////////////////////////////////////////
	// Reference enable, one cycle in 2**CPC_REF_DIV_BITS
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div     <= '0;
			mem_ref <= 1'b0;
		end else begin
			div     <= div + 1'b1;
			mem_ref <= (div == '0);
		end
	end

	////////////////////////////////////////////////////////////
	// Write sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_we  <= 1'b0;
			second  <= 1'b0;
			done    <= 1'b0;
			rom_map <= '0;
		end else begin
			done <= 1'b0;
			if (mem_ref) begin
				if (mem_we) begin
					// Write period ends here
					mem_we <= 1'b0;
					if (wr.replay && !second) begin
						second <= 1'b1;
					end else begin
						second <= 1'b0;
						done   <= 1'b1;
						if (wr.addr.fields.hi_half) begin
							rom_map[wr.addr.fields.page] <= 1'b1;
						end
					end
				end else if (req) begin
					mem_we <= 1'b1;
				end
			end
		end
	end

	// Write port payload, loaded as each write period opens
	always_ff @(posedge clk_sys) begin
		if (mem_ref && req && !mem_we) begin
			mem_bank <= second ? 2'd1 : wr.bank;
			mem_addr <= wr.addr.flat;
			mem_data <= wr.data;
		end
	end

endmodule

//--- logic/cpc_rom_loader.sv
////////////////////////////////////////////////////////////
// ROM download loader for the CPC core
// Host bytes in, paced memory writes and page map out.
// The host may only pulse dl_wr while dl_wait is low
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpc_rom_loader (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         dl_active,
	input  logic [7:0]   dl_index,
	input  logic [15:0]  dl_ext,
	input  logic         dl_wr,
	input  logic [24:0]  dl_addr,
	input  logic [7:0]   dl_data,
	output logic         dl_wait,
	output logic         mem_ref,
	output logic         mem_we,
	output logic [1:0]   mem_bank,
	output logic [22:0]  mem_addr,
	output logic [7:0]   mem_data,
	output logic [255:0] rom_map
);
	import cpc_loader_pkg::*;

	dl_start_t  start_rec;
	mem_write_t wr_req;
	logic       req;
	logic       done;

	rom_ext_decoder ext_dec0 (
		.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active),
		.dl_index(dl_index), .dl_ext(dl_ext), .start(start_rec)
	);

	rom_addr_mapper mapper0 (
		.clk_sys(clk_sys), .reset(reset), .start(start_rec),
		.dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.dl_active(dl_active), .done(done), .dl_wait(dl_wait),
		.req(req), .wr(wr_req)
	);

	rom_write_sequencer seq0 (
		.clk_sys(clk_sys), .reset(reset), .req(req), .wr(wr_req),
		.done(done), .mem_ref(mem_ref), .mem_we(mem_we), .mem_bank(mem_bank),
		.mem_addr(mem_addr), .mem_data(mem_data), .rom_map(rom_map)
	);

endmodule

//--- verification/cpc_rom_loader_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the CPC ROM download loader
// Reads downloads and expected memory writes from the input
// data file, sends the bytes under the dl_wait handshake
// and checks the write port and the page map of the DUT
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cpc_rom_loader_tb;
	import cpc_loader_pkg::*;

	localparam int MAX_TESTS  = 16;
	localparam int MAX_BYTES  = 64;
	localparam int MAX_WRITES = 128;
	// Longest byte is a replay of about 36 cycles
	localparam int BYTE_LIMIT = 60;
	// One reference enable every 8 cycles, one write per enable period
	localparam int REF_PERIOD = 8;

	logic         clk_sys;
	logic         reset;
	logic         dl_active;
	logic [7:0]   dl_index;
	logic [15:0]  dl_ext;
	logic         dl_wr;
	logic [24:0]  dl_addr;
	logic [7:0]   dl_data;
	logic         dl_wait;
	logic         mem_ref;
	logic         mem_we;
	logic [1:0]   mem_bank;
	logic [22:0]  mem_addr;
	logic [7:0]   mem_data;
	logic [255:0] rom_map;

	// Contents of the input file
	logic [8*16-1:0] test_name [0:MAX_TESTS-1];
	logic [7:0]      test_index [0:MAX_TESTS-1];
	logic [15:0]     test_ext [0:MAX_TESTS-1];
	int              test_first_byte [0:MAX_TESTS-1];
	int              test_num_bytes [0:MAX_TESTS-1];
	logic [255:0]    test_map [0:MAX_TESTS-1];
	logic [24:0]     byte_addr [0:MAX_BYTES-1];
	logic [7:0]      byte_data [0:MAX_BYTES-1];
	int              byte_first_wr [0:MAX_BYTES-1];
	int              byte_num_wr [0:MAX_BYTES-1];
	mem_write_t      wr_list [0:MAX_WRITES-1];
	int              num_tests = 0;
	int              num_bytes = 0;
	int              num_writes = 0;
	logic            loaded = 1'b0;

	mem_write_t exp_q[$];
	mem_write_t exp_w;
	int         errors = 0;
	int         write_count = 0;
	int         pass_count = 0;
	int         fail_count = 0;
	int         ref_gap = 0;
	int         we_len = 0;

	cpc_rom_loader dut0 (
		.clk_sys(clk_sys), .reset(reset), .dl_active(dl_active),
		.dl_index(dl_index), .dl_ext(dl_ext), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .dl_wait(dl_wait),
		.mem_ref(mem_ref), .mem_we(mem_we), .mem_bank(mem_bank),
		.mem_addr(mem_addr), .mem_data(mem_data), .rom_map(rom_map)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Input file
	////////////////////////////////////////////////////////////

	task automatic load_input_file(output bit ok);
		int               fd;
		int               code;
		int               cur;
		logic [7:0]       tag;
		logic [8*256-1:0] rest;
		logic [24:0]      addr_v;
		logic [7:0]       data_v;
		logic [7:0]       bit_v;
		logic [1:0]       bank_v;
		ok = 1'b1;
		cur = -1;
		fd = $fopen("verification/rom_loader_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the input data file");
			ok = 1'b0;
		end else begin
			while (ok) begin
				code = $fscanf(fd, "%s", tag);
				if (code != 1) begin
					break;
				end
				case (tag)
					"#": code = $fgets(rest, fd);
					"t": begin
						cur = num_tests;
						num_tests++;
						code = $fscanf(fd, "%s %h %s", test_name[cur], test_index[cur],
						               test_ext[cur]);
						test_first_byte[cur] = num_bytes;
						test_num_bytes[cur]  = 0;
						test_map[cur]        = '0;
					end
					"b": begin
						code = $fscanf(fd, "%h %h", addr_v, data_v);
						byte_addr[num_bytes]     = addr_v;
						byte_data[num_bytes]     = data_v;
						byte_first_wr[num_bytes] = num_writes;
						byte_num_wr[num_bytes]   = 0;
						num_bytes++;
						test_num_bytes[cur]++;
					end
					"w": begin
						code = $fscanf(fd, "%h %h %h", bank_v, addr_v, data_v);
						wr_list[num_writes]           = '0;
						wr_list[num_writes].bank      = bank_v;
						wr_list[num_writes].addr.flat = addr_v[22:0];
						wr_list[num_writes].data      = data_v;
						num_writes++;
						byte_num_wr[num_bytes-1]++;
					end
					"m": begin
						code = $fscanf(fd, "%h", bit_v);
						test_map[cur][bit_v] = 1'b1;
					end
					default: begin
						$display("Unknown record type in the input data file");
						ok = 1'b0;
					end
				endcase
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	endtask

	task automatic check_idle_state();
		if (dl_wait !== 1'b0) begin
			$display("Mismatch dl_wait after reset: expected 0, got %h", dl_wait);
			errors++;
		end
		if (mem_we !== 1'b0) begin
			$display("Mismatch mem_we after reset: expected 0, got %h", mem_we);
			errors++;
		end
		if (rom_map !== '0) begin
			$display("Mismatch rom_map after reset: expected 0, got %h", rom_map);
			errors++;
		end
	endtask

	// Sends one byte and waits for dl_wait to fall
	task automatic send_byte(input int b);
		int edges;
		int k;
		for (k = 0; k < byte_num_wr[b]; k++) begin
			exp_q.push_back(wr_list[byte_first_wr[b] + k]);
		end
		dl_addr = byte_addr[b];
		dl_data = byte_data[b];
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		if (dl_wait !== 1'b1) begin
			$display("dl_wait did not rise one cycle after dl_wr at address %h", byte_addr[b]);
			errors++;
		end
		edges = 1;
		while (dl_wait === 1'b1 && edges < BYTE_LIMIT) begin
			@(posedge clk_sys);
			#1;
			edges++;
		end
		if (dl_wait !== 1'b0) begin
			$display("dl_wait stuck high for %0d cycles at address %h", edges, byte_addr[b]);
			errors++;
		end else if (byte_num_wr[b] == 0 && edges != 2) begin
			$display("Dropped byte held dl_wait for %0d cycles instead of 2", edges);
			errors++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected writes missing for address %h", exp_q.size(), byte_addr[b]);
			errors++;
		end
		exp_q.delete();
	endtask

	task automatic run_test(input int t);
		int order [0:MAX_BYTES-1];
		int i;
		int j;
		int tmp;
		int err_start;
		err_start = errors;
		apply_reset();
		check_idle_state();
		dl_index  = test_index[t];
		dl_ext    = test_ext[t];
		dl_active = 1'b1;
		repeat (2) begin
			@(posedge clk_sys);
			#1;
		end
		// Bytes go out in random order
		for (i = 0; i < test_num_bytes[t]; i++) begin
			order[i] = i;
		end
		for (i = test_num_bytes[t] - 1; i > 0; i--) begin
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < test_num_bytes[t]; i++) begin
			send_byte(test_first_byte[t] + order[i]);
		end
		dl_active = 1'b0;
		@(posedge clk_sys);
		#1;
		if (rom_map !== test_map[t]) begin
			$display("Mismatch rom_map: expected %h, got %h", test_map[t], rom_map);
			errors++;
		end
		if (errors == err_start) begin
			pass_count++;
			$display("Test %0s passed", test_name[t]);
		end else begin
			fail_count++;
			$display("Test %0s failed with %0d errors", test_name[t], errors - err_start);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor of the write port and the handshake
	////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (!reset && dl_wr && dl_wait) begin
			$display("dl_wr was sent while dl_wait was high");
			errors++;
		end
		if (!reset && mem_we && mem_ref) begin
			write_count++;
			if (exp_q.size() == 0) begin
				$display("Unexpected write to bank %h address %h", mem_bank, mem_addr);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				if (mem_bank !== exp_w.bank) begin
					$display("Mismatch mem_bank: expected %h, got %h", exp_w.bank, mem_bank);
					errors++;
				end
				if (mem_addr !== exp_w.addr.flat) begin
					$display("Mismatch mem_addr: expected %h, got %h", exp_w.addr.flat, mem_addr);
					errors++;
				end
				if (mem_data !== exp_w.data) begin
					$display("Mismatch mem_data: expected %h, got %h", exp_w.data, mem_data);
					errors++;
				end
			end
		end
	end

	// Spacing of mem_ref pulses and length of each mem_we period
	always @(negedge clk_sys) begin
		if (reset) begin
			ref_gap = 0;
			we_len  = 0;
		end else begin
			if (mem_ref) begin
				if (ref_gap != 0 && ref_gap != REF_PERIOD) begin
					$display("Mismatch mem_ref period: expected %0h, got %0h", REF_PERIOD,
					         ref_gap);
					errors++;
				end
				ref_gap = 1;
			end else if (ref_gap != 0) begin
				ref_gap++;
			end
			if (mem_we) begin
				we_len++;
			end else if (we_len != 0) begin
				if (we_len != REF_PERIOD) begin
					$display("Mismatch mem_we length: expected %0h, got %0h", REF_PERIOD,
					         we_len);
					errors++;
				end
				we_len = 0;
			end
		end
	end

	// Watchdog sized from the number of bytes in the file
	initial begin
		wait (loaded);
		repeat (num_bytes * 40 + 200) @(posedge clk_sys);
		$display("Timeout, the downloads did not finish in %0d cycles", num_bytes * 40 + 200);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int t;
		int seed;
		bit ok;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_ext    = '0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		seed      = 66989;
		void'($urandom(seed));
		load_input_file(ok);
		loaded = 1'b1;
		if (ok) begin
			for (t = 0; t < num_tests; t++) begin
				run_test(t);
			end
			if (write_count != num_writes) begin
				$display("Saw %0d writes, the input file lists %0d", write_count, num_writes);
				errors++;
			end
		end
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (ok && errors == 0 && fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- cpc_rom_loader.f
+incdir+include
logic/cpc_loader_pkg.sv
logic/rom_ext_decoder.sv
logic/rom_addr_mapper.sv
logic/rom_write_sequencer.sv
logic/cpc_rom_loader.sv
verification/cpc_rom_loader_tb.sv

//--- verification/rom_loader_input.txt
# t name index ext | b dl_addr data | w bank mem_addr data, one line per write of the byte above
# m rom_map bit expected set when the test ends | all numbers hex
t main_6128 00 RO
b 000010 A5
w 0 000010 A5
b 004123 3C
w 0 400123 3C
b 008001 7E
w 0 41C001 7E
b 00FFFF 99
w 0 3FFFFF 99
m 00
m 07
t main_664 00 RO
b 010005 11
w 1 000005 11
b 014200 22
w 1 400200 22
b 018000 33
w 1 41C000 33
b 01C07F 44
w 1 3FC07F 44
# Block 8 is dropped, no write
b 020000 55
m 00
m 07
t exp_07 01 07
b 000000 F3
w 0 41C000 F3
w 1 41C000 F3
b 001ABC C9
w 0 41DABC C9
w 1 41DABC C9
m 07
t exp_zz 80 ZZ
b 000020 01
w 0 000020 01
b 004030 02
w 0 004030 02
t exp_bad 80 QQ
b 004001 5A
w 0 7BC001 5A
b 000002 A6
w 0 7B8002 A6
m EE
m EF
t exp_bank1 C1 10
b 000100 77
w 1 440100 77
b 004200 88
w 1 444200 88
m 10
m 11
